// ==== Makefile ====
# Verilator build for the dual-issue front end
# any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST ?= src.f
TB_TOP ?= frontend_tb
RTL_TOP ?= frontend_top
OBJ_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Done: no errors
VFLAGS ?= --timing --assert
BUILD_FLAGS ?= --binary -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(BUILD_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== rtl/cpu_types_pkg.sv ====
package cpu_types_pkg;

	// byte address and raw instruction word
	typedef logic [31:0] InstAddr_t;
	typedef logic [31:0] Inst_t;
	typedef logic Bit_t;

	// distance between two adjacent instruction words
	localparam InstAddr_t INST_BYTES = 32'd4;
	localparam InstAddr_t ZERO_ADDR = 32'd0;

	// two adjacent words as fetched
	// as the forward pair, inst2_taken tells whether slot 1 issued
	typedef struct packed {
		Inst_t inst1;
		Inst_t inst2;
		Bit_t inst2_taken;
	} InstPair_t;

	// stall levels from the back end
	typedef struct packed {
		Bit_t stall_if;
		Bit_t stall_id;
	} Stall_t;

	// only fetch misalignment can raise an exception here
	typedef struct packed {
		Bit_t valid;
		Bit_t fetch_misaligned;
	} ExceptInfo_t;

	// one lane of the issue bundle
	typedef struct packed {
		Bit_t valid;
		InstAddr_t pc;
		isa_pkg::DecodedInst_t dec;
	} IssueSlot_t;

endpackage

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
	parameter cpu_types_pkg::InstAddr_t RESET_PC = 32'hbfc0_0000
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  cpu_types_pkg::Stall_t       stall,
	input  logic                        flush,
	input  cpu_types_pkg::InstAddr_t    flush_pc,
	input  cpu_types_pkg::InstPair_t    inst_pair_forward,
	output cpu_types_pkg::InstAddr_t    imem_addr,
	input  cpu_types_pkg::Inst_t        imem_rdata0,
	input  cpu_types_pkg::Inst_t        imem_rdata1,
	output cpu_types_pkg::InstAddr_t    if_pc,
	output cpu_types_pkg::InstPair_t    if_inst_pair,
	output cpu_types_pkg::ExceptInfo_t  if_except,
	output cpu_types_pkg::Bit_t         is_hard_reset
);
	import cpu_types_pkg::*;

	InstAddr_t pc_q;
	InstAddr_t pc_step;
	InstAddr_t flush_target;
	Bit_t hard_q;
	Bit_t misaligned_q;

	// two words consumed when slot 1 issued or ID held a bubble
	// otherwise the second word comes back as leftover, so only one step
	always_comb
	begin
		if (inst_pair_forward.inst2_taken || hard_q)
		begin
			pc_step = INST_BYTES << 1;
		end
		else
		begin
			pc_step = INST_BYTES;
		end
	end

	// low bits dropped, misalignment reported through if_except
	assign flush_target = {flush_pc[31:2], 2'b00};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pc_q <= RESET_PC;
			hard_q <= 1'b1;
			misaligned_q <= 1'b0;
		end
		else if (flush)
		begin
			pc_q <= flush_target;
			hard_q <= 1'b1;
			misaligned_q <= |flush_pc[1:0];
		end
		else if (!stall.stall_if)
		begin
			pc_q <= pc_q + pc_step;
			hard_q <= 1'b0;
			misaligned_q <= 1'b0;
		end
	end

	// memory answers both words in the same cycle
	assign imem_addr = pc_q;
	assign if_pc = pc_q;
	assign if_inst_pair = '{inst1: imem_rdata0, inst2: imem_rdata1, inst2_taken: 1'b0};
	assign if_except = '{valid: misaligned_q, fetch_misaligned: misaligned_q};
	assign is_hard_reset = hard_q;

	// steps of 4 and 8 from an aligned start keep every fetch aligned
	a_fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		imem_addr[1:0] == 2'b00)
		else $error("fetch address %h not word aligned", imem_addr);

endmodule

// ==== rtl/frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top #(
	parameter cpu_types_pkg::InstAddr_t RESET_PC = 32'hbfc0_0000
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  cpu_types_pkg::Stall_t       stall,
	input  logic                        flush,
	input  cpu_types_pkg::InstAddr_t    flush_pc,
	output cpu_types_pkg::InstAddr_t    imem_addr,
	input  cpu_types_pkg::Inst_t        imem_rdata0,
	input  cpu_types_pkg::Inst_t        imem_rdata1,
	output cpu_types_pkg::IssueSlot_t   issue0,
	output cpu_types_pkg::IssueSlot_t   issue1,
	output cpu_types_pkg::ExceptInfo_t  id_except
);
	import cpu_types_pkg::*;

	// IF side
	InstAddr_t if_pc;
	InstPair_t if_inst_pair;
	ExceptInfo_t if_except;
	Bit_t is_hard_reset;

	// ID side
	InstAddr_t id_pc;
	Bit_t set_empty_inst;
	Bit_t id_inst_left;
	InstPair_t id_inst_pair_new;
	InstPair_t id_inst_pair_old;

	// pairing decision fed back to IF/ID and fetch
	InstPair_t inst_pair_forward;

	fetch_unit #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk               (clk),
		.arst_n            (arst_n),
		.stall             (stall),
		.flush             (flush),
		.flush_pc          (flush_pc),
		.inst_pair_forward (inst_pair_forward),
		.imem_addr         (imem_addr),
		.imem_rdata0       (imem_rdata0),
		.imem_rdata1       (imem_rdata1),
		.if_pc             (if_pc),
		.if_inst_pair      (if_inst_pair),
		.if_except         (if_except),
		.is_hard_reset     (is_hard_reset)
	);

	if_id u_if_id (
		.clk               (clk),
		.arst_n            (arst_n),
		.if_pc             (if_pc),
		.if_inst_pair      (if_inst_pair),
		.if_except         (if_except),
		.is_hard_reset     (is_hard_reset),
		.inst_pair_forward (inst_pair_forward),
		.stall             (stall),
		.flush             (flush),
		.id_pc             (id_pc),
		.id_except         (id_except),
		.set_empty_inst    (set_empty_inst),
		.id_inst_left      (id_inst_left),
		.id_inst_pair_new  (id_inst_pair_new),
		.id_inst_pair_old  (id_inst_pair_old)
	);

	id_stage u_id (
		.id_pc             (id_pc),
		.id_except         (id_except),
		.set_empty_inst    (set_empty_inst),
		.id_inst_left      (id_inst_left),
		.id_inst_pair_new  (id_inst_pair_new),
		.id_inst_pair_old  (id_inst_pair_old),
		.inst_pair_forward (inst_pair_forward),
		.issue0            (issue0),
		.issue1            (issue1)
	);

endmodule

// ==== rtl/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
	input  cpu_types_pkg::InstAddr_t    id_pc,
	input  cpu_types_pkg::ExceptInfo_t  id_except,
	input  cpu_types_pkg::Bit_t         set_empty_inst,
	input  cpu_types_pkg::Bit_t         id_inst_left,
	input  cpu_types_pkg::InstPair_t    id_inst_pair_new,
	input  cpu_types_pkg::InstPair_t    id_inst_pair_old,
	output cpu_types_pkg::InstPair_t    inst_pair_forward,
	output cpu_types_pkg::IssueSlot_t   issue0,
	output cpu_types_pkg::IssueSlot_t   issue1
);
	import cpu_types_pkg::*;
	import isa_pkg::*;

	Inst_t slot0_inst;
	Inst_t slot1_inst;
	DecodedInst_t dec0;
	DecodedInst_t dec1;
	Bit_t raw_hazard;
	Bit_t mem_conflict;
	Bit_t pair_ok;

	// leftover word goes first and the first new word follows
	always_comb
	begin
		if (id_inst_left)
		begin
			slot0_inst = id_inst_pair_old.inst2;
			slot1_inst = id_inst_pair_new.inst1;
		end
		else
		begin
			slot0_inst = id_inst_pair_new.inst1;
			slot1_inst = id_inst_pair_new.inst2;
		end
	end

	inst_decode u_dec0 (
		.inst (slot0_inst),
		.dec  (dec0)
	);

	inst_decode u_dec1 (
		.inst (slot1_inst),
		.dec  (dec1)
	);

	// slot 1 reads what slot 0 writes in the same cycle
	assign raw_hazard = dec0.writes_reg &&
		((reads_rs(dec1.op) && dec1.rs == dec0.dest) ||
		(reads_rt(dec1.op) && dec1.rt == dec0.dest));

	// single memory port downstream
	assign mem_conflict = dec0.is_mem && dec1.is_mem;

	// control transfer and faults stay alone in slot 0
	assign pair_ok = !raw_hazard && !mem_conflict && !dec1.is_branch &&
		dec0.op != OP_INVALID && dec1.op != OP_INVALID && !id_except.valid;

	always_comb
	begin
		issue0.valid = !set_empty_inst;
		issue0.pc = id_pc;
		issue0.dec = dec0;
		issue1.valid = !set_empty_inst && pair_ok;
		issue1.pc = id_pc + INST_BYTES;
		issue1.dec = dec1;
		// a bubble consumed nothing and fetch moves a full pair ahead
		inst_pair_forward.inst1 = slot0_inst;
		inst_pair_forward.inst2 = slot1_inst;
		inst_pair_forward.inst2_taken = set_empty_inst || pair_ok;
	end

	// pc handed over by IF/ID, including the leftover minus 4 path
	always_comb
	begin
		if (!set_empty_inst)
		begin
			a_id_pc_aligned: assert (id_pc[1:0] == 2'b00)
				else $error("ID pc %h not word aligned", id_pc);
		end
	end

endmodule

// ==== rtl/if_id.sv ====
`timescale 1ns/1ps

module if_id (
	input  logic                        clk,
	input  logic                        arst_n,
	input  cpu_types_pkg::InstAddr_t    if_pc,
	input  cpu_types_pkg::InstPair_t    if_inst_pair,
	input  cpu_types_pkg::ExceptInfo_t  if_except,
	input  cpu_types_pkg::Bit_t         is_hard_reset,
	input  cpu_types_pkg::InstPair_t    inst_pair_forward,
	input  cpu_types_pkg::Stall_t       stall,
	input  logic                        flush,
	output cpu_types_pkg::InstAddr_t    id_pc,
	output cpu_types_pkg::ExceptInfo_t  id_except,
	output cpu_types_pkg::Bit_t         set_empty_inst,
	output cpu_types_pkg::Bit_t         id_inst_left,
	output cpu_types_pkg::InstPair_t    id_inst_pair_new,
	output cpu_types_pkg::InstPair_t    id_inst_pair_old
);
	import cpu_types_pkg::*;

	Bit_t bubble;
	Bit_t leftover;

	// ID moves on while IF cannot deliver or everything is thrown away
	assign bubble = flush || (stall.stall_if && !stall.stall_id);

	// second word of the current ID pair did not issue
	// after reset or flush there is nothing left over
	assign leftover = !inst_pair_forward.inst2_taken && !is_hard_reset;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			set_empty_inst <= 1'b1;
			id_inst_left <= 1'b0;
			id_pc <= ZERO_ADDR;
			id_except <= '0;
		end
		else if (bubble)
		begin
			set_empty_inst <= 1'b1;
			id_pc <= ZERO_ADDR;
			id_except <= '0;
		end
		else if (!stall.stall_if)
		begin
			set_empty_inst <= 1'b0;
			id_inst_left <= leftover;
			id_except <= if_except;
			// leftover word sits one slot before the new fetch pc
			id_pc <= leftover ? if_pc - INST_BYTES : if_pc;
		end
	end

	// new pair from IF and the pair ID just looked at
	// old pair supplies the leftover inst2
	always_ff @(posedge clk)
	begin
		if (!stall.stall_if)
		begin
			id_inst_pair_new <= if_inst_pair;
			id_inst_pair_old <= inst_pair_forward;
		end
	end

	// the first pair after a flush starts fresh with no leftover word
	a_flush_no_leftover: assert property (@(posedge clk) disable iff (!arst_n)
		flush ##1 (!flush && !stall.stall_if) |=> !id_inst_left)
		else $error("leftover word carried across a flush");

endmodule

// ==== rtl/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
	input  cpu_types_pkg::Inst_t   inst,
	output isa_pkg::DecodedInst_t  dec
);
	import isa_pkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;
	RegIdx_t rs;
	RegIdx_t rt;
	RegIdx_t rd;
	RegIdx_t dest;
	Opcode_t op;

	// raw fields
	assign opcode = inst[OPCODE_HI:OPCODE_LO];
	assign funct = inst[FUNCT_HI:FUNCT_LO];
	assign rs = inst[RS_HI:RS_LO];
	assign rt = inst[RT_HI:RT_LO];
	assign rd = inst[RD_HI:RD_LO];

	// opcode class
	always_comb
	begin
		op = OP_INVALID;
		if (inst == '0)
		begin
			op = OP_NOP;
		end
		else
		begin
			case (opcode)
				OPC_SPECIAL:
				begin
					// only the listed R-type functs are supported
					case (funct)
						FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT: op = OP_ALU_R;
						default: op = OP_INVALID;
					endcase
				end
				OPC_ADDIU: op = OP_ADDIU;
				OPC_LW: op = OP_LW;
				OPC_SW: op = OP_SW;
				OPC_BEQ: op = OP_BEQ;
				OPC_J: op = OP_J;
				default: op = OP_INVALID;
			endcase
		end
	end

	// destination register
	// R-type writes rd, immediate and load forms write rt
	always_comb
	begin
		case (op)
			OP_ALU_R: dest = rd;
			OP_ADDIU, OP_LW: dest = rt;
			default: dest = '0;
		endcase
	end

	always_comb
	begin
		dec.op = op;
		dec.rs = rs;
		dec.rt = rt;
		dec.dest = dest;
		// writes to r0 are dropped
		dec.writes_reg = (dest != '0);
		dec.is_mem = op inside {OP_LW, OP_SW};
		dec.is_branch = op inside {OP_BEQ, OP_J};
	end

endmodule

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

	// bit positions inside a 32-bit instruction word
	localparam int OPCODE_HI = 31;
	localparam int OPCODE_LO = 26;
	localparam int RS_HI = 25;
	localparam int RS_LO = 21;
	localparam int RT_HI = 20;
	localparam int RT_LO = 16;
	localparam int RD_HI = 15;
	localparam int RD_LO = 11;
	localparam int FUNCT_HI = 5;
	localparam int FUNCT_LO = 0;

	// primary opcodes understood by the decoder
	localparam logic [5:0] OPC_SPECIAL = 6'h00;
	localparam logic [5:0] OPC_J = 6'h02;
	localparam logic [5:0] OPC_BEQ = 6'h04;
	localparam logic [5:0] OPC_ADDIU = 6'h09;
	localparam logic [5:0] OPC_LW = 6'h23;
	localparam logic [5:0] OPC_SW = 6'h2b;

	// funct values accepted under OPC_SPECIAL
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;

	typedef enum logic [2:0] {
		OP_ALU_R,
		OP_ADDIU,
		OP_LW,
		OP_SW,
		OP_BEQ,
		OP_J,
		OP_NOP,
		OP_INVALID
	} Opcode_t;

	typedef logic [4:0] RegIdx_t;

	// one decoded slot, 21 bits
	typedef struct packed {
		Opcode_t op;
		RegIdx_t rs;
		RegIdx_t rt;
		RegIdx_t dest;
		logic writes_reg;
		logic is_mem;
		logic is_branch;
	} DecodedInst_t;

	// source operands actually read by each class
	function automatic logic reads_rs(Opcode_t op);
		return op inside {OP_ALU_R, OP_ADDIU, OP_LW, OP_SW, OP_BEQ};
	endfunction

	function automatic logic reads_rt(Opcode_t op);
		return op inside {OP_ALU_R, OP_SW, OP_BEQ};
	endfunction

endpackage

// ==== src.f ====
rtl/isa_pkg.sv
rtl/cpu_types_pkg.sv
rtl/inst_decode.sv
rtl/fetch_unit.sv
rtl/if_id.sv
rtl/id_stage.sv
rtl/frontend_top.sv
verif/frontend_tb.sv

// ==== verif/frontend_tb.sv ====
`timescale 1ns/1ps

module frontend_tb;
	import cpu_types_pkg::*;
	import isa_pkg::*;

	localparam InstAddr_t RESET_PC = 32'h0000_0040;
	localparam int MEM_WORDS = 256;
	localparam int CLK_NS = 10;
	localparam int RESET_CYCLES = 4;
	// cycles per test
	// the watchdog budget is their sum
	localparam int IDLE_CYCLES = 20;
	localparam int RUN_CYCLES = 400;
	localparam int STALL_CYCLES = 200;
	localparam int FLUSH_CYCLES = 200;
	localparam int MIX_CYCLES = 400;
	localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + RUN_CYCLES + STALL_CYCLES +
		FLUSH_CYCLES + MIX_CYCLES;

	logic clk;
	logic arst_n;
	Stall_t stall;
	logic flush;
	InstAddr_t flush_pc;
	InstAddr_t imem_addr;
	InstAddr_t imem_next;
	Inst_t imem_rdata0;
	Inst_t imem_rdata1;
	IssueSlot_t issue0;
	IssueSlot_t issue1;
	ExceptInfo_t id_except;

	Inst_t mem [MEM_WORDS];
	integer seed = 59610;
	int errors = 0;
	int errors_mark = 0;
	int test_count = 0;
	int failed_tests = 0;

	// reference state of the ID bundle
	logic exp_valid;
	InstAddr_t expect_pc;
	logic expect_exc;
	DecodedInst_t exp_dec0;
	DecodedInst_t exp_dec1;
	logic exp_pair;

	// history for reset, flush and stall checks
	logic arst_q = 1'b0;
	logic flush_q;
	logic held_q;
	IssueSlot_t prev_issue0;
	IssueSlot_t prev_issue1;

	// how often each check was exercised
	int pair_hits = 0;
	int single_hits = 0;
	int stall_hits = 0;
	int flush_hits = 0;
	int mis_hits = 0;

	frontend_top #(
		.RESET_PC (RESET_PC)
	) dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.stall       (stall),
		.flush       (flush),
		.flush_pc    (flush_pc),
		.imem_addr   (imem_addr),
		.imem_rdata0 (imem_rdata0),
		.imem_rdata1 (imem_rdata1),
		.issue0      (issue0),
		.issue1      (issue1),
		.id_except   (id_except)
	);

	// combinational instruction memory wrapping every 1 KiB
	assign imem_next = imem_addr + 32'd4;
	assign imem_rdata0 = mem[imem_addr[9:2]];
	assign imem_rdata1 = mem[imem_next[9:2]];

	initial
	begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// mostly legal words
	// registers kept in r0..r3 so neighbours collide often
	function automatic Inst_t random_inst();
		logic [31:0] r;
		logic [5:0] fn;
		RegIdx_t rs;
		RegIdx_t rt;
		RegIdx_t rd;
		r = $random(seed);
		rs = {3'b000, r[9:8]};
		rt = {3'b000, r[11:10]};
		rd = {3'b000, r[13:12]};
		case (r[18:16])
			3'd0: fn = FN_ADDU;
			3'd1: fn = FN_SUBU;
			3'd2: fn = FN_AND;
			3'd3: fn = FN_OR;
			3'd4: fn = FN_XOR;
			3'd5: fn = FN_SLT;
			default: fn = 6'h00;
		endcase
		case (r[2:0])
			3'd0, 3'd1: return {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
			3'd2: return {OPC_ADDIU, rs, rt, r[31:16]};
			3'd3: return {OPC_LW, rs, rt, r[31:16]};
			3'd4: return {OPC_SW, rs, rt, r[31:16]};
			3'd5: return {OPC_BEQ, rs, rt, r[31:16]};
			3'd6: return r[3] ? {OPC_J, r[31:6]} : 32'h0;
			default: return $random(seed);
		endcase
	endfunction

	// decode rule for one word
	function automatic DecodedInst_t decode_rule(Inst_t w);
		DecodedInst_t d;
		d.rs = w[25:21];
		d.rt = w[20:16];
		d.dest = 5'd0;
		d.op = OP_INVALID;
		if (w == 32'h0)
			d.op = OP_NOP;
		else
		begin
			case (w[31:26])
				OPC_SPECIAL:
				begin
					if (w[5:0] inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT})
						d.op = OP_ALU_R;
				end
				OPC_ADDIU: d.op = OP_ADDIU;
				OPC_LW: d.op = OP_LW;
				OPC_SW: d.op = OP_SW;
				OPC_BEQ: d.op = OP_BEQ;
				OPC_J: d.op = OP_J;
				default: d.op = OP_INVALID;
			endcase
		end
		// R-type writes rd, addiu and lw write rt
		if (d.op == OP_ALU_R)
			d.dest = w[15:11];
		else if (d.op == OP_ADDIU || d.op == OP_LW)
			d.dest = w[20:16];
		d.writes_reg = (d.dest != 5'd0);
		d.is_mem = (d.op == OP_LW || d.op == OP_SW);
		d.is_branch = (d.op == OP_BEQ || d.op == OP_J);
		return d;
	endfunction

	// dual issue allowed only without hazard, second memory op, branch or fault
	function automatic logic pair_allowed(DecodedInst_t d0, DecodedInst_t d1, logic exc);
		logic uses_rs;
		logic uses_rt;
		logic hazard;
		uses_rs = d1.op inside {OP_ALU_R, OP_ADDIU, OP_LW, OP_SW, OP_BEQ};
		uses_rt = d1.op inside {OP_ALU_R, OP_SW, OP_BEQ};
		hazard = d0.writes_reg &&
			((uses_rs && d1.rs == d0.dest) || (uses_rt && d1.rt == d0.dest));
		return !hazard && !(d0.is_mem && d1.is_mem) && !d1.is_branch &&
			d0.op != OP_INVALID && d1.op != OP_INVALID && !exc;
	endfunction

	always_comb
	begin
		exp_dec0 = decode_rule(mem[expect_pc[9:2]]);
		exp_dec1 = decode_rule(mem[expect_pc[9:2] + 8'd1]);
		exp_pair = pair_allowed(exp_dec0, exp_dec1, expect_exc);
	end

	// program order model with one bundle consumed per unstalled edge
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			exp_valid <= 1'b0;
			expect_pc <= RESET_PC;
			expect_exc <= 1'b0;
		end
		else if (flush)
		begin
			exp_valid <= 1'b0;
			expect_pc <= {flush_pc[31:2], 2'b00};
			expect_exc <= |flush_pc[1:0];
		end
		else if (!stall.stall_if)
		begin
			exp_valid <= 1'b1;
			if (exp_valid)
			begin
				expect_pc <= expect_pc + (exp_pair ? 32'd8 : 32'd4);
				expect_exc <= 1'b0;
			end
		end
		else if (!stall.stall_id)
			exp_valid <= 1'b0;
	end

	always @(posedge clk)
		arst_q <= arst_n;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			flush_q <= 1'b0;
			held_q <= 1'b0;
			prev_issue0 <= '0;
			prev_issue1 <= '0;
		end
		else
		begin
			flush_q <= flush;
			held_q <= stall.stall_if && stall.stall_id && !flush;
			prev_issue0 <= issue0;
			prev_issue1 <= issue1;
		end
	end

	always @(posedge clk)
	begin
		if (arst_n && exp_valid && !stall.stall_if && !flush)
		begin
			if (exp_pair)
				pair_hits++;
			else
				single_hits++;
			if (expect_exc)
				mis_hits++;
		end
		if (arst_n && held_q)
			stall_hits++;
		if (arst_n && flush_q)
			flush_hits++;
	end

	a_reset_idle: assert property (@(posedge clk)
		(!arst_n || !arst_q) |-> !issue0.valid && !issue1.valid)
		else
		begin
			errors++;
			$display("Fail issue0.valid/issue1.valid in reset: got %h/%h expected 0/0",
				$sampled(issue0.valid), $sampled(issue1.valid));
		end

	a_reset_fetch: assert property (@(posedge clk)
		!arst_n |-> imem_addr == RESET_PC)
		else
		begin
			errors++;
			$display("Fail imem_addr in reset: got %h expected %h", $sampled(imem_addr),
				RESET_PC);
		end

	a_valid: assert property (@(posedge clk) disable iff (!arst_n)
		issue0.valid == exp_valid)
		else
		begin
			errors++;
			$display("Fail issue0.valid: got %h expected %h", $sampled(issue0.valid),
				$sampled(exp_valid));
		end

	a_order: assert property (@(posedge clk) disable iff (!arst_n)
		exp_valid |-> issue0.pc == expect_pc)
		else
		begin
			errors++;
			$display("Fail issue0.pc: got %h expected %h", $sampled(issue0.pc),
				$sampled(expect_pc));
		end

	a_dec0: assert property (@(posedge clk) disable iff (!arst_n)
		exp_valid |-> issue0.dec == exp_dec0)
		else
		begin
			errors++;
			$display("Fail issue0.dec: got %h expected %h", $sampled(issue0.dec),
				$sampled(exp_dec0));
		end

	a_pair: assert property (@(posedge clk) disable iff (!arst_n)
		issue1.valid == (exp_valid && exp_pair))
		else
		begin
			errors++;
			$display("Fail issue1.valid: got %h expected %h", $sampled(issue1.valid),
				$sampled(exp_valid && exp_pair));
		end

	a_pc1: assert property (@(posedge clk) disable iff (!arst_n)
		(exp_valid && exp_pair) |-> issue1.pc == expect_pc + 32'd4)
		else
		begin
			errors++;
			$display("Fail issue1.pc: got %h expected %h", $sampled(issue1.pc),
				$sampled(expect_pc) + 32'd4);
		end

	a_dec1: assert property (@(posedge clk) disable iff (!arst_n)
		(exp_valid && exp_pair) |-> issue1.dec == exp_dec1)
		else
		begin
			errors++;
			$display("Fail issue1.dec: got %h expected %h", $sampled(issue1.dec),
				$sampled(exp_dec1));
		end

	a_flush_empty: assert property (@(posedge clk) disable iff (!arst_n)
		flush_q |-> !issue0.valid && !issue1.valid)
		else
		begin
			errors++;
			$display("Fail issue0.valid/issue1.valid after flush: got %h/%h expected 0/0",
				$sampled(issue0.valid), $sampled(issue1.valid));
		end

	a_except: assert property (@(posedge clk) disable iff (!arst_n)
		exp_valid |-> id_except == {expect_exc, expect_exc})
		else
		begin
			errors++;
			$display("Fail id_except: got %h expected %h", $sampled(id_except),
				$sampled({expect_exc, expect_exc}));
		end

	a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
		held_q |-> issue0 == prev_issue0 && issue1 == prev_issue1)
		else
		begin
			errors++;
			$display("Fail issue0/issue1 under stall: got %h/%h expected %h/%h",
				$sampled(issue0), $sampled(issue1), $sampled(prev_issue0),
				$sampled(prev_issue1));
		end

	task automatic fill_memory();
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = random_inst();
	endtask

	// random full stall bursts and single-cycle flush pulses
	task automatic drive_cycles(input int n, input int stall_pct, input int flush_pct);
		int r;
		int stall_left;
		InstAddr_t fpc;
		stall_left = 0;
		repeat (n)
		begin
			@(posedge clk);
			r = $unsigned($random(seed)) % 100;
			fpc = $random(seed);
			// about half the flush targets are aligned
			if (fpc[4])
				fpc[1:0] = 2'b00;
			if (stall_left == 0 && r < stall_pct)
				stall_left = 1 + ($unsigned($random(seed)) % 6);
			if (stall_left > 0)
			begin
				stall <= '{stall_if: 1'b1, stall_id: 1'b1};
				stall_left--;
			end
			else
				stall <= '0;
			flush <= (r >= 100 - flush_pct);
			flush_pc <= fpc;
		end
	endtask

	task automatic finish_test(input string name);
		int n;
		n = errors - errors_mark;
		test_count++;
		if (n != 0)
			failed_tests++;
		$display("test %s: %s, %0d errors", name, (n == 0) ? "ok" : "FAILED", n);
		errors_mark = errors;
	endtask

	task automatic require_reached(input string what, input int hits);
		if (hits == 0)
		begin
			errors++;
			$display("the %s check was never exercised", what);
		end
	endtask

	initial
	begin
		arst_n = 1'b1;
		stall = '0;
		flush = 1'b0;
		flush_pc = '0;
		fill_memory();
		// reset pulse starts just after time zero
		#1 arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		drive_cycles(IDLE_CYCLES, 0, 0);
		finish_test("reset");
		drive_cycles(RUN_CYCLES, 0, 0);
		finish_test("decode and pairing");
		drive_cycles(STALL_CYCLES, 20, 0);
		finish_test("stall");
		drive_cycles(FLUSH_CYCLES, 0, 8);
		finish_test("flush");
		drive_cycles(MIX_CYCLES, 15, 5);
		finish_test("mixed");
		require_reached("dual issue", pair_hits);
		require_reached("single issue", single_hits);
		require_reached("stall hold", stall_hits);
		require_reached("flush bubble", flush_hits);
		require_reached("misaligned fetch", mis_hits);
		finish_test("check reach");
		$display("tests run %0d, failed %0d, errors %0d", test_count, failed_tests, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// budget is the summed test length plus some slack
	initial
	begin
		#((TOTAL_CYCLES + 100) * CLK_NS);
		$display("watchdog expired after %0d cycles, run did not complete", TOTAL_CYCLES + 100);
		$display("Done: errors found");
		$finish;
	end

endmodule
